// File: design/rv_exec_pkg.sv
// Shared constants and types for the RV64 integer execute stage.
// Holds the data and instruction widths, the opcode and funct encodings
// of the kept base integer subset, and the instruction word union.
// Every design file refers to these through rv_exec_pkg:: scoped names.
package rv_exec_pkg;

  localparam int xlen      = 64;
  localparam int ilen      = 32;
  localparam int reg_idx_w = 5;

  localparam logic [xlen-1:0] pc_step = xlen'(4);

  localparam logic [6:0] op_arith  = 7'b0110011;
  localparam logic [6:0] op_arithi = 7'b0010011;
  localparam logic [6:0] op_branch = 7'b1100011;
  localparam logic [6:0] op_load   = 7'b0000011;
  localparam logic [6:0] op_store  = 7'b0100011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_jalr   = 7'b1100111;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;

  localparam logic [2:0] funct3_add  = 3'b000; // also sub
  localparam logic [2:0] funct3_sll  = 3'b001;
  localparam logic [2:0] funct3_slt  = 3'b010;
  localparam logic [2:0] funct3_sltu = 3'b011;
  localparam logic [2:0] funct3_xor  = 3'b100;
  localparam logic [2:0] funct3_srl  = 3'b101; // also sra
  localparam logic [2:0] funct3_or   = 3'b110;
  localparam logic [2:0] funct3_and  = 3'b111;

  localparam logic [2:0] funct3_beq  = 3'b000;
  localparam logic [2:0] funct3_bne  = 3'b001;
  localparam logic [2:0] funct3_blt  = 3'b100;
  localparam logic [2:0] funct3_bge  = 3'b101;
  localparam logic [2:0] funct3_bltu = 3'b110;
  localparam logic [2:0] funct3_bgeu = 3'b111;

  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_alt  = 7'b0100000; // sub, sra

  typedef struct packed {
    logic [6:0]           funct7;
    logic [4:0]           rs2;
    logic [4:0]           rs1;
    logic [2:0]           funct3;
    logic [reg_idx_w-1:0] rd;
    logic [6:0]           opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0]          imm; // top six bits act as funct6 for shifts
    logic [4:0]           rs1;
    logic [2:0]           funct3;
    logic [reg_idx_w-1:0] rd;
    logic [6:0]           opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo; // sits where rd would be
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [ilen-13:0]     imm;
    logic [reg_idx_w-1:0] rd;
    logic [6:0]           opcode;
  } u_fmt_t;

  typedef union packed {
    r_fmt_t r_fmt;
    i_fmt_t i_fmt;
    s_fmt_t s_fmt;
    b_fmt_t b_fmt;
    u_fmt_t u_fmt;
  } instr_t;

endpackage

// File: design/rv_int_alu.sv
// Integer ALU of the execute stage, purely combinational.
// Produces the write data and destination for register and immediate
// arithmetic, LUI, AUIPC, the JAL/JALR link, load addresses and stores.
// alu_wr_o flags that a register or memory write exists.
module rv_int_alu (
  input  logic [rv_exec_pkg::xlen-1:0] pc_i,
  input  logic [rv_exec_pkg::xlen-1:0] in1_i,
  input  logic [rv_exec_pkg::xlen-1:0] in2_i,
  input  rv_exec_pkg::instr_t          inst_i,
  output logic [rv_exec_pkg::xlen-1:0] alu_data_o,
  output logic [rv_exec_pkg::xlen-1:0] alu_addr_o,
  output logic                         alu_wr_o
);

  logic [rv_exec_pkg::xlen-1:0] imm_i;
  logic [rv_exec_pkg::xlen-1:0] imm_s;
  logic [rv_exec_pkg::xlen-1:0] imm_u;
  logic [rv_exec_pkg::xlen-1:0] op_b;
  logic [rv_exec_pkg::xlen-1:0] alu_res;
  logic [6:0]                   f7;
  logic                         is_reg;
  logic                         sub_sel;
  logic                         sra_sel;
  logic                         f_ok;

  assign f7     = inst_i.r_fmt.funct7;
  assign is_reg = inst_i.r_fmt.opcode == rv_exec_pkg::op_arith;

  assign imm_i = {{(rv_exec_pkg::xlen-12){inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};
  assign imm_s = {{(rv_exec_pkg::xlen-12){inst_i.s_fmt.imm_hi[6]}},
                  inst_i.s_fmt.imm_hi, inst_i.s_fmt.imm_lo};
  assign imm_u = {{(rv_exec_pkg::xlen-32){inst_i.u_fmt.imm[19]}}, inst_i.u_fmt.imm, 12'b0};

  assign op_b    = is_reg ? in2_i : imm_i;
  assign sub_sel = is_reg && f7 == rv_exec_pkg::funct7_alt;
  assign sra_sel = f7[6:1] == rv_exec_pkg::funct7_alt[6:1]; // funct6 for immediates

  // legal funct7 / funct6 per funct3
  always_comb begin
    case (inst_i.r_fmt.funct3)
      rv_exec_pkg::funct3_add:
        f_ok = !is_reg || f7 == rv_exec_pkg::funct7_base || f7 == rv_exec_pkg::funct7_alt;
      rv_exec_pkg::funct3_sll:
        f_ok = is_reg ? f7 == rv_exec_pkg::funct7_base
                      : f7[6:1] == rv_exec_pkg::funct7_base[6:1];
      rv_exec_pkg::funct3_srl:
        f_ok = is_reg ? (f7 == rv_exec_pkg::funct7_base || f7 == rv_exec_pkg::funct7_alt)
                      : (f7[6:1] == rv_exec_pkg::funct7_base[6:1] || sra_sel);
      default:
        f_ok = !is_reg || f7 == rv_exec_pkg::funct7_base;
    endcase
  end

  always_comb begin
    alu_res = in1_i + op_b;
    case (inst_i.r_fmt.funct3)
      rv_exec_pkg::funct3_add:  if (sub_sel) alu_res = in1_i - op_b;
      rv_exec_pkg::funct3_sll:  alu_res = in1_i << op_b[5:0];
      rv_exec_pkg::funct3_slt:  alu_res = {63'b0, $signed(in1_i) < $signed(op_b)};
      rv_exec_pkg::funct3_sltu: alu_res = {63'b0, in1_i < op_b}; // imm already sign-extended
      rv_exec_pkg::funct3_xor:  alu_res = in1_i ^ op_b;
      rv_exec_pkg::funct3_srl: begin
        if (sra_sel) alu_res = $signed(in1_i) >>> op_b[5:0];
        else         alu_res = in1_i >> op_b[5:0];
      end
      rv_exec_pkg::funct3_or:   alu_res = in1_i | op_b;
      default:                  alu_res = in1_i & op_b;
    endcase
  end

  always_comb begin
    alu_data_o = alu_res;
    alu_addr_o = {{(rv_exec_pkg::xlen-rv_exec_pkg::reg_idx_w){1'b0}}, inst_i.r_fmt.rd};
    alu_wr_o   = 1'b1;
    case (inst_i.r_fmt.opcode)
      rv_exec_pkg::op_arith, rv_exec_pkg::op_arithi: alu_wr_o = f_ok;
      rv_exec_pkg::op_load: alu_data_o = in1_i + imm_i; // effective address
      rv_exec_pkg::op_store: begin
        alu_data_o = in2_i;
        alu_addr_o = in1_i + imm_s;
      end
      rv_exec_pkg::op_jal, rv_exec_pkg::op_jalr: alu_data_o = pc_i + rv_exec_pkg::pc_step;
      rv_exec_pkg::op_lui:   alu_data_o = imm_u;
      rv_exec_pkg::op_auipc: alu_data_o = pc_i + imm_u;
      default:               alu_wr_o = 1'b0; // branches and unknown opcodes
    endcase
  end

endmodule

// File: design/rv_branch_unit.sv
// Branch and JALR target unit, purely combinational.
// Resolves the six conditional branches and gives the next pc;
// br_valid_o marks that br_target_o carries a redirect.
module rv_branch_unit (
  input  logic [rv_exec_pkg::xlen-1:0] pc_i,
  input  logic [rv_exec_pkg::xlen-1:0] in1_i,
  input  logic [rv_exec_pkg::xlen-1:0] in2_i,
  input  rv_exec_pkg::instr_t          inst_i,
  output logic [rv_exec_pkg::xlen-1:0] br_target_o,
  output logic                         br_valid_o
);

  logic [rv_exec_pkg::xlen-1:0] imm_b;
  logic [rv_exec_pkg::xlen-1:0] jalr_sum;
  logic                         taken;
  logic                         cond_ok;

  assign imm_b = {{(rv_exec_pkg::xlen-13){inst_i.b_fmt.imm_12}}, inst_i.b_fmt.imm_12,
                  inst_i.b_fmt.imm_11, inst_i.b_fmt.imm_10_5, inst_i.b_fmt.imm_4_1, 1'b0};
  assign jalr_sum = in1_i + {{(rv_exec_pkg::xlen-12){inst_i.i_fmt.imm[11]}}, inst_i.i_fmt.imm};

  always_comb begin
    cond_ok = 1'b1;
    taken   = 1'b0;
    case (inst_i.b_fmt.funct3)
      rv_exec_pkg::funct3_beq:  taken = in1_i == in2_i;
      rv_exec_pkg::funct3_bne:  taken = in1_i != in2_i;
      rv_exec_pkg::funct3_blt:  taken = $signed(in1_i) < $signed(in2_i);
      rv_exec_pkg::funct3_bge:  taken = $signed(in1_i) >= $signed(in2_i);
      rv_exec_pkg::funct3_bltu: taken = in1_i < in2_i;
      rv_exec_pkg::funct3_bgeu: taken = in1_i >= in2_i;
      default:                  cond_ok = 1'b0; // 010, 011 undefined
    endcase
  end

  always_comb begin
    br_target_o = pc_i + rv_exec_pkg::pc_step; // fall-through
    br_valid_o  = 1'b0;
    if (inst_i.b_fmt.opcode == rv_exec_pkg::op_branch) begin
      br_valid_o = cond_ok;
      if (taken) br_target_o = pc_i + imm_b;
    end else if (inst_i.b_fmt.opcode == rv_exec_pkg::op_jalr) begin
      br_target_o = {jalr_sum[rv_exec_pkg::xlen-1:1], 1'b0};
      br_valid_o  = 1'b1;
    end
  end

endmodule

// File: design/rv_exec_stage.sv
// Handshake and output register of the execute stage.
// Checks that the operands an instruction class needs are valid, takes
// it when the output register can accept, and registers the ALU and
// branch results for one cycle. Outputs hold while downstream retries.
module rv_exec_stage (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  rv_exec_pkg::instr_t          inst_i,
  input  logic                         pc_valid_i,
  input  logic                         in1_valid_i,
  input  logic                         in2_valid_i,
  input  logic                         inst_valid_i,
  input  logic [rv_exec_pkg::xlen-1:0] alu_data_i,
  input  logic [rv_exec_pkg::xlen-1:0] alu_addr_i,
  input  logic [rv_exec_pkg::xlen-1:0] br_target_i,
  input  logic                         alu_wr_i,
  input  logic                         br_valid_i,
  output logic                         in_retry_o,
  output logic [rv_exec_pkg::xlen-1:0] rdata_o,
  output logic                         rdata_valid_o,
  output logic [rv_exec_pkg::xlen-1:0] raddr_o,
  output logic                         raddr_valid_o,
  output logic [rv_exec_pkg::xlen-1:0] branch_pc_o,
  output logic                         branch_pc_valid_o,
  input  logic                         out_retry_i
);

  logic need_in1;
  logic need_in2;
  logic ops_ok;
  logic stall;
  logic take;
  logic wr_q;
  logic br_q;

  // operand requirement per class
  always_comb begin
    case (inst_i.r_fmt.opcode)
      rv_exec_pkg::op_arith, rv_exec_pkg::op_arithi, rv_exec_pkg::op_branch,
      rv_exec_pkg::op_load, rv_exec_pkg::op_store: begin
        need_in1 = 1'b1;
        need_in2 = 1'b1;
      end
      rv_exec_pkg::op_jalr, rv_exec_pkg::op_lui, rv_exec_pkg::op_auipc: begin
        need_in1 = 1'b1;
        need_in2 = 1'b0;
      end
      default: begin // jal and unknown opcodes
        need_in1 = 1'b0;
        need_in2 = 1'b0;
      end
    endcase
  end

  assign ops_ok = pc_valid_i && inst_valid_i && (in1_valid_i || !need_in1) &&
                  (in2_valid_i || !need_in2);
  assign stall      = (wr_q || br_q) && out_retry_i; // result held, not accepted
  assign take       = ops_ok && !stall;
  assign in_retry_o = !take;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_q <= 1'b0;
      br_q <= 1'b0;
    end else if (!stall) begin
      wr_q <= take && alu_wr_i;
      br_q <= take && br_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      rdata_o     <= alu_data_i;
      raddr_o     <= alu_addr_i;
      branch_pc_o <= br_target_i;
    end
  end

  assign rdata_valid_o     = wr_q;
  assign raddr_valid_o     = wr_q;
  assign branch_pc_valid_o = br_q;

endmodule

// File: design/rv_exec_top.sv
// Top level of the RV64 integer execute stage.
// The ALU and the branch unit work side by side on the same inputs,
// and the stage registers their results behind one valid/retry handshake.
module rv_exec_top (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic [rv_exec_pkg::xlen-1:0] pc_i,
  input  logic [rv_exec_pkg::xlen-1:0] in1_i,
  input  logic [rv_exec_pkg::xlen-1:0] in2_i,
  input  rv_exec_pkg::instr_t          inst_i,
  input  logic                         pc_valid_i,
  input  logic                         in1_valid_i,
  input  logic                         in2_valid_i,
  input  logic                         inst_valid_i,
  output logic                         in_retry_o,
  output logic [rv_exec_pkg::xlen-1:0] rdata_o,
  output logic                         rdata_valid_o,
  output logic [rv_exec_pkg::xlen-1:0] raddr_o,
  output logic                         raddr_valid_o,
  output logic [rv_exec_pkg::xlen-1:0] branch_pc_o,
  output logic                         branch_pc_valid_o,
  input  logic                         out_retry_i
);

  logic [rv_exec_pkg::xlen-1:0] alu_data;
  logic [rv_exec_pkg::xlen-1:0] alu_addr;
  logic                         alu_wr;
  logic [rv_exec_pkg::xlen-1:0] br_target;
  logic                         br_valid;

  rv_int_alu i_alu (
    .pc_i       (pc_i),
    .in1_i      (in1_i),
    .in2_i      (in2_i),
    .inst_i     (inst_i),
    .alu_data_o (alu_data),
    .alu_addr_o (alu_addr),
    .alu_wr_o   (alu_wr)
  );

  rv_branch_unit i_branch (
    .pc_i        (pc_i),
    .in1_i       (in1_i),
    .in2_i       (in2_i),
    .inst_i      (inst_i),
    .br_target_o (br_target),
    .br_valid_o  (br_valid)
  );

  rv_exec_stage i_stage (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .inst_i            (inst_i),
    .pc_valid_i        (pc_valid_i),
    .in1_valid_i       (in1_valid_i),
    .in2_valid_i       (in2_valid_i),
    .inst_valid_i      (inst_valid_i),
    .alu_data_i        (alu_data),
    .alu_addr_i        (alu_addr),
    .br_target_i       (br_target),
    .alu_wr_i          (alu_wr),
    .br_valid_i        (br_valid),
    .in_retry_o        (in_retry_o),
    .rdata_o           (rdata_o),
    .rdata_valid_o     (rdata_valid_o),
    .raddr_o           (raddr_o),
    .raddr_valid_o     (raddr_valid_o),
    .branch_pc_o       (branch_pc_o),
    .branch_pc_valid_o (branch_pc_valid_o),
    .out_retry_i       (out_retry_i)
  );

endmodule

// File: include/exec_model.svh
// Reference model of the execute stage outputs, included inside the testbench.
// Decodes the raw instruction word by bit position, following the RISC-V
// base integer encodings of the kept operations.
`ifndef EXEC_MODEL_SVH
`define EXEC_MODEL_SVH

// {in1 needed, in2 needed}; jal and unknown opcodes need neither
function automatic logic [1:0] operand_need(input logic [31:0] ins);
  if (ins[6:0] inside {rv_exec_pkg::op_arith, rv_exec_pkg::op_arithi, rv_exec_pkg::op_branch,
                       rv_exec_pkg::op_load, rv_exec_pkg::op_store})
    return 2'b11;
  if (ins[6:0] inside {rv_exec_pkg::op_jalr, rv_exec_pkg::op_lui, rv_exec_pkg::op_auipc})
    return 2'b10;
  return 2'b00;
endfunction

function automatic logic writes_back(input logic [31:0] ins);
  return ins[6:0] inside {rv_exec_pkg::op_arith, rv_exec_pkg::op_arithi, rv_exec_pkg::op_load,
                          rv_exec_pkg::op_store, rv_exec_pkg::op_jal, rv_exec_pkg::op_jalr,
                          rv_exec_pkg::op_lui, rv_exec_pkg::op_auipc};
endfunction

function automatic logic redirects(input logic [31:0] ins);
  return ins[6:0] == rv_exec_pkg::op_branch || ins[6:0] == rv_exec_pkg::op_jalr;
endfunction

function automatic logic [63:0] wb_data(input logic [63:0] pc, a, b_reg,
                                        input logic [31:0] ins);
  logic [63:0] imm_i;
  logic [63:0] imm_u;
  logic [63:0] b;
  imm_i = {{52{ins[31]}}, ins[31:20]};
  imm_u = {{32{ins[31]}}, ins[31:12], 12'b0};
  b = (ins[6:0] == rv_exec_pkg::op_arith) ? b_reg : imm_i;
  case (ins[6:0])
    rv_exec_pkg::op_load:  return a + imm_i; // effective address
    rv_exec_pkg::op_store: return b_reg;
    rv_exec_pkg::op_jal, rv_exec_pkg::op_jalr: return pc + 64'd4;
    rv_exec_pkg::op_lui:   return imm_u;
    rv_exec_pkg::op_auipc: return pc + imm_u;
    default: ;
  endcase
  case (ins[14:12])
    3'b000: return (ins[6:0] == rv_exec_pkg::op_arith && ins[30]) ? a - b : a + b;
    3'b001: return a << b[5:0];
    3'b010: return {63'b0, $signed(a) < $signed(b)};
    3'b011: return {63'b0, a < b};
    3'b100: return a ^ b;
    3'b101: begin
      if (ins[30])
        return $signed(a) >>> b[5:0];
      return a >> b[5:0];
    end
    3'b110: return a | b;
    default: return a & b;
  endcase
endfunction

function automatic logic [63:0] dest_addr(input logic [63:0] a, input logic [31:0] ins);
  if (ins[6:0] == rv_exec_pkg::op_store)
    return a + {{52{ins[31]}}, ins[31:25], ins[11:7]};
  return {59'b0, ins[11:7]};
endfunction

function automatic logic [63:0] next_pc(input logic [63:0] pc, a, b, input logic [31:0] ins);
  logic taken;
  if (ins[6:0] == rv_exec_pkg::op_jalr)
    return (a + {{52{ins[31]}}, ins[31:20]}) & ~64'd1;
  case (ins[14:12])
    3'b000:  taken = a == b;
    3'b001:  taken = a != b;
    3'b100:  taken = $signed(a) < $signed(b);
    3'b101:  taken = $signed(a) >= $signed(b);
    3'b110:  taken = a < b;
    default: taken = a >= b;
  endcase
  if (taken)
    return pc + {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
  return pc + 64'd4;
endfunction

`endif

// File: bench/tb_exec.sv
// Testbench for the RV64 execute stage top level.
// Drives random legal instructions, some unsupported opcodes, dropped
// operand valids and downstream retry, and checks outputs and in_retry_o
// every cycle against the model in exec_model.svh.
module tb_exec;

  typedef struct packed {
    logic        wr;
    logic [63:0] data;
    logic [63:0] addr;
    logic        br;
    logic [63:0] bpc;
  } exp_t;

  logic        clk_i = 1'b0;
  logic        reset_i;
  logic [63:0] pc_i, in1_i, in2_i;
  logic [31:0] inst_i;
  logic        pc_valid_i, in1_valid_i, in2_valid_i, inst_valid_i;
  logic        out_retry_i;
  logic        in_retry_o;
  logic [63:0] rdata_o, raddr_o, branch_pc_o;
  logic        rdata_valid_o, raddr_valid_o, branch_pc_valid_o;
  integer      seed;
  integer      stall_cnt;
  logic        new_inst;
  exp_t        exp_q[$]; // taken, not yet transferred

  `include "exec_model.svh"

  always #4 clk_i = ~clk_i;

  rv_exec_top i_dut (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .pc_i              (pc_i),
    .in1_i             (in1_i),
    .in2_i             (in2_i),
    .inst_i            (inst_i),
    .pc_valid_i        (pc_valid_i),
    .in1_valid_i       (in1_valid_i),
    .in2_valid_i       (in2_valid_i),
    .inst_valid_i      (inst_valid_i),
    .in_retry_o        (in_retry_o),
    .rdata_o           (rdata_o),
    .rdata_valid_o     (rdata_valid_o),
    .raddr_o           (raddr_o),
    .raddr_valid_o     (raddr_valid_o),
    .branch_pc_o       (branch_pc_o),
    .branch_pc_valid_o (branch_pc_valid_o),
    .out_retry_i       (out_retry_i)
  );

  task automatic check_value(input string name, input logic [63:0] act, input logic [63:0] exp);
    if (act !== exp) begin
      $display("error: %s actual %h expected %h", name, act, exp);
      $display("Simulation FAILED");
      $fatal(1);
    end
  endtask

  task automatic report_timeout(input int cycles);
    $display("timeout: no output arrived within %0d cycles", cycles);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic pick_instr();
    logic [31:0] r;
    integer      kind;
    r      = $random(seed);
    kind   = {$random(seed)} % 15;
    pc_i   = {$random(seed), $random(seed) & 32'hffff_fffc};
    in1_i  = {$random(seed), $random(seed)};
    in2_i  = ({$random(seed)} % 4 == 0) ? in1_i : {$random(seed), $random(seed)};
    inst_i = r;
    case (kind)
      0, 1, 2: begin
        inst_i[6:0]   = rv_exec_pkg::op_arith;
        inst_i[31:25] = ((r[14:12] == 3'b000 || r[14:12] == 3'b101) && r[30]) ?
                        rv_exec_pkg::funct7_alt : rv_exec_pkg::funct7_base;
      end
      3, 4, 5: begin
        inst_i[6:0] = rv_exec_pkg::op_arithi;
        if (r[13:12] == 2'b01)
          inst_i[31:26] = {1'b0, r[14] & r[30], 4'b0}; // slli, srli, srai
      end
      6, 7: begin
        inst_i[6:0] = rv_exec_pkg::op_branch;
        if (r[14:13] == 2'b01)
          inst_i[14] = 1'b1; // no branch on 010, 011
      end
      8:  inst_i[6:0] = rv_exec_pkg::op_load;
      9:  inst_i[6:0] = rv_exec_pkg::op_store;
      10: inst_i[6:0] = rv_exec_pkg::op_jal;
      11: inst_i[6:0] = rv_exec_pkg::op_jalr;
      12: inst_i[6:0] = rv_exec_pkg::op_lui;
      13: inst_i[6:0] = rv_exec_pkg::op_auipc;
      default: inst_i[6:0] = r[0] ? 7'b0001111 : 7'b1110011; // fence, system
    endcase
  endtask

  // runs at the falling edge and commits what the next rising edge does
  task automatic compare_outputs();
    exp_t        e;
    logic [1:0]  need;
    logic        take;
    e    = (exp_q.size() > 0) ? exp_q[0] : '0;
    need = operand_need(inst_i);
    check_value("rdata_valid_o", rdata_valid_o, e.wr);
    check_value("raddr_valid_o", raddr_valid_o, e.wr);
    check_value("branch_pc_valid_o", branch_pc_valid_o, e.br);
    if (e.wr) begin
      check_value("rdata_o", rdata_o, e.data);
      check_value("raddr_o", raddr_o, e.addr);
    end
    if (e.br)
      check_value("branch_pc_o", branch_pc_o, e.bpc);
    take = pc_valid_i && inst_valid_i && (in1_valid_i || !need[1]) &&
           (in2_valid_i || !need[0]) && !(exp_q.size() > 0 && out_retry_i);
    check_value("in_retry_o", in_retry_o, !take);
    if (exp_q.size() > 0 && !out_retry_i) begin
      void'(exp_q.pop_front());
      stall_cnt = 0;
    end else if (exp_q.size() > 0) begin
      stall_cnt = stall_cnt + 1;
      if (stall_cnt > 40)
        report_timeout(40);
    end
    new_inst = take;
    if (take && (writes_back(inst_i) || redirects(inst_i))) begin
      e.wr   = writes_back(inst_i);
      e.data = wb_data(pc_i, in1_i, in2_i, inst_i);
      e.addr = dest_addr(in1_i, inst_i);
      e.br   = redirects(inst_i);
      e.bpc  = next_pc(pc_i, in1_i, in2_i, inst_i);
      exp_q.push_back(e);
    end
  endtask

  initial begin
    seed         = 5;
    stall_cnt    = 0;
    reset_i      = 1'b1;
    pc_i         = '0;
    in1_i        = '0;
    in2_i        = '0;
    inst_i       = '0;
    pc_valid_i   = 1'b0;
    in1_valid_i  = 1'b0;
    in2_valid_i  = 1'b0;
    inst_valid_i = 1'b0;
    out_retry_i  = 1'b0;
    repeat (8) @(posedge clk_i);
    #1 reset_i = 1'b0;
    @(negedge clk_i);
    compare_outputs(); // idle after reset
    new_inst = 1'b1;
    repeat (3000) begin
      @(posedge clk_i);
      #1;
      if (new_inst)
        pick_instr();
      pc_valid_i   = {$random(seed)} % 8 != 0;
      in1_valid_i  = {$random(seed)} % 6 != 0;
      in2_valid_i  = {$random(seed)} % 6 != 0;
      inst_valid_i = {$random(seed)} % 8 != 0;
      out_retry_i  = {$random(seed)} % 4 == 0;
      @(negedge clk_i);
      compare_outputs();
    end
    @(posedge clk_i);
    #1;
    pc_valid_i   = 1'b0;
    inst_valid_i = 1'b0;
    out_retry_i  = 1'b0;
    for (int n = 0; exp_q.size() > 0; n++) begin
      if (n == 10)
        report_timeout(10);
      @(negedge clk_i);
      compare_outputs();
    end
    @(negedge clk_i);
    compare_outputs(); // outputs empty again
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: verilog.f
+incdir+include
design/rv_exec_pkg.sv
design/rv_int_alu.sv
design/rv_branch_unit.sv
design/rv_exec_stage.sv
design/rv_exec_top.sv
bench/tb_exec.sv
